// ==== list.f ====
+incdir+.
iq_pkg.sv
dispatch_capture.sv
iq_entry_array.sv
issue_select.sv
issue_queue.sv
issue_queue_sva.sv
tb_issue_queue.sv

// ==== run.sh ====
#!/bin/sh
# build and run the issue queue testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_issue_queue -f list.f \
    -o tb_issue_queue && ./obj_dir/tb_issue_queue > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; } || true
grep -q "PASS: all tests" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"

// ==== tb_issue_queue.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "iq_config.svh"

module tb_issue_queue;

    import iq_pkg::*;

    localparam int RESET_CYCLES    = 16;
    localparam int DIRECTED_CYCLES = 120;
    localparam int RANDOM_CYCLES   = 400;
    localparam int CYCLE_LIMIT     = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 200;

    // expected outputs of one cycle
    typedef struct packed {
        logic   full;
        logic   valid;
        issue_t issue;
    } expect_t;

    logic      clk;
    logic      rst_n;
    logic      flush;
    logic      dispatch_valid;
    dispatch_t dispatch;
    logic      full;
    wb_bus_t   wb [`IQ_WB_PORTS];
    logic      mul_ready;
    logic      div_ready;
    logic      issue_valid;
    issue_t    issue;

    iq_entry_t   model_q [$];  // oldest first
    logic [15:0] lfsr;
    int          cycle;
    int          issue_count;
    int          flag_errors;
    int          op_errors;
    int          issue_errors;
    int          other_errors;

    issue_queue uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .full           (full),
        .wb             (wb),
        .mul_ready      (mul_ready),
        .div_ready      (div_ready),
        .issue_valid    (issue_valid),
        .issue          (issue)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ------------------------------------------------------------
    // random source
    // ------------------------------------------------------------

    // 16 bit galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};  // one step per bit
        end
        return v;
    endfunction

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------

    function automatic logic needs_div(input iq_op_e op);
        case (op)
            op_div, op_divu, op_rem, op_remu: return 1'b1;
            default:                          return 1'b0;
        endcase
    endfunction

    // first bus in index order with the tag supplies the value
    function automatic src_operand_t snoop(input src_operand_t s);
        src_operand_t r;
        r = s;
        for (int p = 0; p < `IQ_WB_PORTS; p++) begin
            if (r.pending && wb[p].valid && (wb[p].tag == s.tag)) begin
                r.pending = 1'b0;
                r.value   = wb[p].data;
            end
        end
        return r;
    endfunction

    function automatic int oldest_ready();
        for (int i = 0; i < model_q.size(); i++) begin
            if (!model_q[i].src1.pending && !model_q[i].src2.pending) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic expect_t predict();
        expect_t e;
        int      idx;
        e      = '0;
        idx    = oldest_ready();
        e.full = (model_q.size() == `IQ_DEPTH);
        if (idx >= 0) begin
            e.valid           = needs_div(model_q[idx].op) ? div_ready : mul_ready;
            e.issue.op        = model_q[idx].op;
            e.issue.dst_tag   = model_q[idx].dst_tag;
            e.issue.rs1_value = model_q[idx].src1.value;
            e.issue.rs2_value = model_q[idx].src2.value;
        end
        return e;
    endfunction

    // state after the coming edge
    task automatic advance_model(input expect_t e);
        int        idx;
        iq_entry_t n;
        idx = oldest_ready();  // picked before this cycle's wakeup
        if (flush) begin
            model_q.delete();
        end else begin
            for (int i = 0; i < model_q.size(); i++) begin
                n         = model_q[i];
                n.src1    = snoop(n.src1);
                n.src2    = snoop(n.src2);
                model_q[i] = n;
            end
            if (e.valid) begin
                model_q.delete(idx);
            end
            if (dispatch_valid && !e.full) begin
                n      = dispatch;
                n.src1 = snoop(dispatch.src1);
                n.src2 = snoop(dispatch.src2);
                model_q.push_back(n);
            end
        end
    endtask

    // ------------------------------------------------------------
    // compare
    // ------------------------------------------------------------

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            flag_errors++;
            $display("[ERROR] %0t %s expected %0b actual %0b", $time, name, exp, act);
        end
    endtask

    task automatic check_op(input iq_op_e exp, input iq_op_e act);
        if (act !== exp) begin
            op_errors++;
            $display("[ERROR] %0t issue.op expected %s actual %s", $time, exp.name(), act.name());
        end
    endtask

    task automatic check_issue(input issue_t exp, input issue_t act);
        if (act !== exp) begin
            issue_errors++;
            $display("[ERROR] %0t issue expected %h actual %h", $time, exp, act);
        end
    endtask

    // inputs and registered state are both settled mid cycle
    always @(negedge clk) begin : compare
        expect_t e;
        if (rst_n) begin
            e = predict();
            check_flag("full", e.full, full);
            check_flag("issue_valid", e.valid, issue_valid);
            if (e.valid && issue_valid) begin
                check_op(e.issue.op, issue.op);
                check_issue(e.issue, issue);
            end
            if (issue_valid) begin
                issue_count++;
            end
            advance_model(e);
        end
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic idle(input int n);
        repeat (n) step();
    endtask

    function automatic src_operand_t have(input word_t v);
        src_operand_t s;
        s.pending = 1'b0;
        s.tag     = '0;
        s.value   = v;
        return s;
    endfunction

    function automatic src_operand_t await_tag(input rob_tag_t t);
        src_operand_t s;
        s.pending = 1'b1;
        s.tag     = t;
        s.value   = '0;
        return s;
    endfunction

    // held for one edge and dropped by the DUT when full
    task automatic send(input iq_op_e op, input rob_tag_t dst,
                        input src_operand_t s1, input src_operand_t s2);
        dispatch_valid   = 1'b1;
        dispatch.op      = op;
        dispatch.dst_tag = dst;
        dispatch.src1    = s1;
        dispatch.src2    = s2;
        step();
        dispatch_valid = 1'b0;
    endtask

    task automatic broadcast(input int port, input rob_tag_t t, input word_t d);
        wb[port].valid = 1'b1;
        wb[port].tag   = t;
        wb[port].data  = d;
    endtask

    task automatic quiet_wb();
        for (int p = 0; p < `IQ_WB_PORTS; p++) begin
            wb[p] = '0;
        end
    endtask

    task automatic wait_issued(input int total);
        while (issue_count < total) begin
            step();
        end
    endtask

    task automatic drive_random();
        logic [2:0] op_bits;
        op_bits          = 3'(rand_bits(3));
        dispatch_valid   = (rand_bits(1) != 32'd0);
        dispatch.op      = iq_op_e'(op_bits);
        dispatch.dst_tag = rob_tag_t'(rand_bits(`ROB_TAG_W));
        dispatch.src1    = have(word_t'(rand_bits(`WORD_W)));
        dispatch.src2    = have(word_t'(rand_bits(`WORD_W)));
        dispatch.src1.pending = (rand_bits(1) != 32'd0);
        dispatch.src1.tag     = rob_tag_t'(rand_bits(`ROB_TAG_W));
        dispatch.src2.pending = (rand_bits(1) != 32'd0);
        dispatch.src2.tag     = rob_tag_t'(rand_bits(`ROB_TAG_W));
        for (int p = 0; p < `IQ_WB_PORTS; p++) begin
            wb[p].valid = (rand_bits(1) != 32'd0);
            wb[p].tag   = rob_tag_t'(rand_bits(`ROB_TAG_W));
            wb[p].data  = word_t'(rand_bits(`WORD_W));
        end
        flush = (rand_bits(5) == 32'd0);  // rare
        if (flush) begin
            mul_ready = 1'b0;
            div_ready = 1'b0;
        end else begin
            mul_ready = (rand_bits(2) != 32'd0);
            div_ready = (rand_bits(2) != 32'd0);
        end
    endtask

    // ------------------------------------------------------------
    // tests
    // ------------------------------------------------------------

    initial begin : run
        int base;
        rst_n = 1'b0;
        flush = 1'b0;
        dispatch_valid = 1'b0;
        dispatch = '0;
        mul_ready = 1'b0;
        div_ready = 1'b0;
        quiet_wb();
        lfsr = 16'd5694;
        cycle = 0;
        issue_count = 0;
        flag_errors = 0;
        op_errors = 0;
        issue_errors = 0;
        other_errors = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        idle(2);

        // in order issue of ready ops
        mul_ready = 1'b1;
        div_ready = 1'b1;
        base = issue_count;
        send(op_mul, 4'd1, have(32'h11), have(32'h22));
        send(op_div, 4'd2, have(32'h33), have(32'h44));
        send(op_mulhu, 4'd3, have(32'h55), have(32'h66));
        wait_issued(base + 3);

        // wakeup through every bus
        base = issue_count;
        for (int p = 0; p < `IQ_WB_PORTS; p++) begin
            send(op_mulh, rob_tag_t'(4 + p), await_tag(rob_tag_t'(8 + p)), have(word_t'(p)));
            idle(1);
            broadcast(p, rob_tag_t'(8 + p), word_t'(32'hA000 + p));
            step();
            quiet_wb();
        end
        broadcast(2, 4'd12, 32'hB00C);  // producer ends in the dispatch cycle
        send(op_divu, 4'd7, have(32'h7), await_tag(4'd12));
        quiet_wb();
        send(op_rem, 4'd8, await_tag(4'd13), await_tag(4'd14));
        broadcast(1, 4'd13, 32'hC001);  // two buses on one tag
        broadcast(2, 4'd13, 32'hC002);
        broadcast(0, 4'd14, 32'hC000);
        step();
        quiet_wb();
        wait_issued(base + 5);

        // younger ready op overtakes and a busy unit blocks
        base = issue_count;
        send(op_mul, 4'd9, await_tag(4'd3), have(32'h9));
        send(op_div, 4'd10, have(32'hA), have(32'hB));
        idle(1);
        broadcast(0, 4'd3, 32'hD003);
        step();
        quiet_wb();
        wait_issued(base + 2);
        div_ready = 1'b0;
        base = issue_count;
        send(op_remu, 4'd11, have(32'h1), have(32'h2));
        send(op_mulhsu, 4'd12, have(32'h3), have(32'h4));
        idle(4);
        div_ready = 1'b1;
        wait_issued(base + 2);

        // fill to full and drop the fifth offer
        mul_ready = 1'b0;
        div_ready = 1'b0;
        base = issue_count;
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            send(op_mul, rob_tag_t'(i), have(word_t'(i)), have(word_t'(i + 100)));
        end
        check_flag("full", 1'b1, full);
        send(op_div, 4'd15, have(32'hF), have(32'hF));
        mul_ready = 1'b1;
        div_ready = 1'b1;
        wait_issued(base + `IQ_DEPTH);
        idle(3);
        if (issue_count != base + `IQ_DEPTH) begin
            other_errors++;
            $display("dropped dispatch still reached the queue, %0d ops issued",
                     issue_count - base);
        end

        // flush drops everything
        mul_ready = 1'b0;
        div_ready = 1'b0;
        send(op_mul, 4'd1, have(32'h1), have(32'h1));
        send(op_div, 4'd2, have(32'h2), have(32'h2));
        flush = 1'b1;
        step();
        flush = 1'b0;
        base = issue_count;
        mul_ready = 1'b1;
        div_ready = 1'b1;
        idle(4);
        if (issue_count != base) begin
            other_errors++;
            $display("an op issued after the flush emptied the queue");
        end
        send(op_divu, 4'd5, have(32'h5), have(32'h6));
        wait_issued(base + 1);

        // random mix against the model
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            drive_random();
            step();
        end
        dispatch_valid = 1'b0;
        flush = 1'b0;
        quiet_wb();
        idle(2);

        $display("errors: flag %0d, op %0d, issue %0d, other %0d, assert %0d",
                 flag_errors, op_errors, issue_errors, other_errors,
                 uut.u_sva.fail_count);
        if (flag_errors + op_errors + issue_errors + other_errors
            + uut.u_sva.fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== issue_queue_sva.sv ====
`default_nettype none
`timescale 1ns/10ps

module issue_queue_sva (
    input logic           clk,
    input logic           rst_n,
    input logic           flush,
    input logic           full,
    input logic           mul_ready,
    input logic           div_ready,
    input logic           issue_valid,
    input iq_pkg::issue_t issue
);

    import iq_pkg::*;

    logic div_class;   // op goes to the divider
    int   fail_count;  // failed assertions so far

    initial fail_count = 0;

    assign div_class = issue.op inside {op_div, op_divu, op_rem, op_remu};

    // ------------------------------------------------------------
    // properties
    // ------------------------------------------------------------

    a_unit_ready: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid |-> (div_class ? div_ready : mul_ready))
        else begin
            $error("issue_valid high while the target unit is busy");
            fail_count++;
        end

    // queue is empty right after a flush
    a_flush_empty: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> (!full && !issue_valid))
        else begin
            $error("queue not empty after flush");
            fail_count++;
        end

    a_full_drop: assert property (@(posedge clk) disable iff (!rst_n)
        !full |-> ($past(!full) || $past(issue_valid) || $past(flush)))
        else begin
            $error("full dropped without an issue or flush");
            fail_count++;
        end

endmodule

bind issue_queue issue_queue_sva u_sva (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .full        (full),
    .mul_ready   (mul_ready),
    .div_ready   (div_ready),
    .issue_valid (issue_valid),
    .issue       (issue)
);

`default_nettype wire

// ==== issue_queue.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "iq_config.svh"

module issue_queue (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              dispatch_valid,
    input  iq_pkg::dispatch_t dispatch,
    output logic              full,
    input  iq_pkg::wb_bus_t   wb [`IQ_WB_PORTS],
    input  logic              mul_ready,
    input  logic              div_ready,
    output logic              issue_valid,
    output iq_pkg::issue_t    issue
);

    import iq_pkg::*;

    logic       write_en;
    iq_entry_t  write_entry;            // dispatch with same-cycle wakeup folded in
    iq_entry_t  entries [`IQ_DEPTH];
    slot_mask_t valid_mask;
    logic       issue_fire;
    slot_idx_t  issue_slot;

    // ------------------------------------------------------------
    // input side
    // ------------------------------------------------------------

    dispatch_capture u_capture (
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .wb             (wb),
        .full           (full),
        .write_en       (write_en),
        .write_entry    (write_entry)
    );

    // ------------------------------------------------------------
    // storage
    // ------------------------------------------------------------

    iq_entry_array u_array (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .write_en    (write_en),
        .write_entry (write_entry),
        .wb          (wb),
        .issue_fire  (issue_fire),
        .issue_slot  (issue_slot),
        .entries     (entries),
        .valid_mask  (valid_mask),
        .full        (full)
    );

    // ------------------------------------------------------------
    // output side
    // ------------------------------------------------------------

    issue_select u_select (
        .entries    (entries),
        .valid_mask (valid_mask),
        .mul_ready  (mul_ready),
        .div_ready  (div_ready),
        .issue_fire (issue_fire),
        .issue_slot (issue_slot),
        .issue      (issue)
    );

    assign issue_valid = issue_fire;  // the unit takes the op without a separate accept

endmodule

`default_nettype wire

// ==== issue_select.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "iq_config.svh"

module issue_select (
    input  iq_pkg::iq_entry_t  entries [`IQ_DEPTH],
    input  iq_pkg::slot_mask_t valid_mask,
    input  logic               mul_ready,
    input  logic               div_ready,
    output logic               issue_fire,
    output iq_pkg::slot_idx_t  issue_slot,
    output iq_pkg::issue_t     issue
);

    import iq_pkg::*;

    slot_mask_t ready_mask;  // valid with both operands present
    logic       any_ready;
    logic       unit_ready;  // unit needed by the picked op
    iq_entry_t  pick;

    // ------------------------------------------------------------
    // oldest ready slot
    // ------------------------------------------------------------

    always_comb begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            ready_mask[i] = valid_mask[i] && !entries[i].src1.pending
                            && !entries[i].src2.pending;
        end
    end

    // slot 0 is the oldest, so the lowest set bit wins
    always_comb begin
        any_ready  = 1'b0;
        issue_slot = '0;
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            if (ready_mask[i] && !any_ready) begin
                any_ready  = 1'b1;
                issue_slot = slot_idx_t'(i);
            end
        end
    end

    assign pick = entries[issue_slot];

    // ------------------------------------------------------------
    // unit gating
    // ------------------------------------------------------------

    // a busy unit blocks everything and younger ops of the other class wait too
    always_comb begin
        case (pick.op)
            op_mul, op_mulh, op_mulhsu, op_mulhu: unit_ready = mul_ready;
            op_div, op_divu, op_rem, op_remu:     unit_ready = div_ready;
            default:                              unit_ready = 1'b0;
        endcase
    end

    assign issue_fire = any_ready && unit_ready;

    always_comb begin
        issue.op        = pick.op;
        issue.dst_tag   = pick.dst_tag;
        issue.rs1_value = pick.src1.value;
        issue.rs2_value = pick.src2.value;
    end

endmodule

`default_nettype wire

// ==== iq_entry_array.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "iq_config.svh"

module iq_entry_array (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  logic               write_en,
    input  iq_pkg::iq_entry_t  write_entry,
    input  iq_pkg::wb_bus_t    wb [`IQ_WB_PORTS],
    input  logic               issue_fire,
    input  iq_pkg::slot_idx_t  issue_slot,
    output iq_pkg::iq_entry_t  entries [`IQ_DEPTH],
    output iq_pkg::slot_mask_t valid_mask,
    output logic               full
);

    import iq_pkg::*;

    localparam int PTR_W = `IQ_DEPTH + 1;

    // one-hot count moving 0_0001 -> 0_0010 -> ... -> 1_0000 (full) on push
    // and walking back down on pop, with 0_0001 meaning empty
    logic [PTR_W-1:0] fifo_p;

    iq_entry_t  woken   [`IQ_DEPTH];  // stored entries after wakeup
    iq_entry_t  shifted [`IQ_DEPTH];  // after compaction
    iq_entry_t  next_q  [`IQ_DEPTH];
    slot_mask_t shift_mask;           // slot takes the contents from above
    slot_mask_t write_mask;           // one-hot landing slot of a dispatch

    // ------------------------------------------------------------
    // occupancy pointer
    // ------------------------------------------------------------

    // write and issue together leave the count unchanged
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fifo_p <= PTR_W'(1);
        end else if (flush) begin
            fifo_p <= PTR_W'(1);  // branch or exception drops everything
        end else if (write_en && !issue_fire) begin
            fifo_p <= fifo_p << 1;
        end else if (issue_fire && !write_en) begin
            fifo_p <= fifo_p >> 1;
        end
    end

    assign full = fifo_p[`IQ_DEPTH];

    // slot i is valid when the pointer sits above it
    always_comb begin : mask_gen
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            seen          = seen | fifo_p[i];
            valid_mask[i] = !seen;
        end
    end

    // ------------------------------------------------------------
    // wakeup of stored operands
    // ------------------------------------------------------------

    always_comb begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            woken[i] = entries[i];
            if (valid_mask[i]) begin
                woken[i].src1 = wake_operand(entries[i].src1, wb);
                woken[i].src2 = wake_operand(entries[i].src2, wb);
            end
        end
    end

    // ------------------------------------------------------------
    // compaction and write
    // ------------------------------------------------------------

    for (genvar i = 0; i < `IQ_DEPTH; i++) begin : g_slot

        // every slot at or above the issued one moves down by one
        assign shift_mask[i] = issue_fire && (slot_idx_t'(i) >= issue_slot);

        // on issue the pointer slot itself is one too high
        assign write_mask[i] = write_en && (issue_fire ? fifo_p[i+1] : fifo_p[i]);

        if (i < `IQ_DEPTH - 1) begin : g_inner
            // the shifted value carries this cycle's wakeup too
            assign shifted[i] = shift_mask[i] ? woken[i+1] : woken[i];
        end else begin : g_top
            // top slot has nothing above and turns invalid on a shift
            assign shifted[i] = woken[i];
        end

        assign next_q[i] = write_mask[i] ? write_entry : shifted[i];
    end

    // slot payload registers
    always_ff @(posedge clk) begin
        entries <= next_q;
    end

endmodule

`default_nettype wire

// ==== dispatch_capture.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "iq_config.svh"

module dispatch_capture (
    input  logic              dispatch_valid,
    input  iq_pkg::dispatch_t dispatch,
    input  iq_pkg::wb_bus_t   wb [`IQ_WB_PORTS],
    input  logic              full,
    output logic              write_en,
    output iq_pkg::iq_entry_t write_entry
);

    import iq_pkg::*;

    src_operand_t src1_res;  // source 1 after same-cycle wakeup
    src_operand_t src2_res;

    // ------------------------------------------------------------
    // acceptance
    // ------------------------------------------------------------

    // an offer while full is dropped and the sender retries
    assign write_en = dispatch_valid && !full;

    // ------------------------------------------------------------
    // same-cycle writeback fold
    // ------------------------------------------------------------

    // a producer finishing in the dispatch cycle is folded in here
    // because stored entries only see it from the next edge on
    assign src1_res = wake_operand(dispatch.src1, wb);
    assign src2_res = wake_operand(dispatch.src2, wb);

    always_comb begin
        write_entry.op      = dispatch.op;
        write_entry.dst_tag = dispatch.dst_tag;
        write_entry.src1    = src1_res;
        write_entry.src2    = src2_res;
    end

endmodule

`default_nettype wire

// ==== iq_pkg.sv ====
`default_nettype none

`include "iq_config.svh"

package iq_pkg;

    // ------------------------------------------------------------
    // widths with a meaning
    // ------------------------------------------------------------
    typedef logic [`ROB_TAG_W-1:0]        rob_tag_t;
    typedef logic [`WORD_W-1:0]           word_t;
    typedef logic [$clog2(`IQ_DEPTH)-1:0] slot_idx_t;
    typedef logic [`IQ_DEPTH-1:0]         slot_mask_t;

    // mul class in the lower half, div class in the upper half
    typedef enum logic [2:0] {
        op_mul    = 3'd0,
        op_mulh   = 3'd1,
        op_mulhsu = 3'd2,
        op_mulhu  = 3'd3,
        op_div    = 3'd4,
        op_divu   = 3'd5,
        op_rem    = 3'd6,
        op_remu   = 3'd7
    } iq_op_e;

    typedef struct packed {
        logic     pending;  // value still awaited
        rob_tag_t tag;      // producer
        word_t    value;
    } src_operand_t;

    typedef struct packed {
        iq_op_e       op;
        rob_tag_t     dst_tag;
        src_operand_t src1;
        src_operand_t src2;
    } dispatch_t;

    // stored form of a dispatched op
    typedef dispatch_t iq_entry_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    data;
    } wb_bus_t;

    typedef struct packed {
        iq_op_e   op;
        rob_tag_t dst_tag;
        word_t    rs1_value;
        word_t    rs2_value;
    } issue_t;

    // wakes one operand from the writeback buses
    // lowest bus index wins when two carry the same tag
    function automatic src_operand_t wake_operand(input src_operand_t src,
                                                  input wb_bus_t      wb [`IQ_WB_PORTS]);
        src_operand_t res;
        res = src;
        for (int p = `IQ_WB_PORTS - 1; p >= 0; p--) begin
            if (src.pending && wb[p].valid && (wb[p].tag == src.tag)) begin
                res.pending = 1'b0;
                res.value   = wb[p].data;
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire

// ==== iq_config.svh ====
`ifndef IQ_CONFIG_SVH
`define IQ_CONFIG_SVH

// ------------------------------------------------------------
// issue queue sizing
// ------------------------------------------------------------

// queue slots with the oldest op in slot 0
`define IQ_DEPTH 4

// width of the reorder buffer tag used for wakeup
`define ROB_TAG_W 4

// operand and result width
`define WORD_W 32

// writeback buses snooped for wakeup
`define IQ_WB_PORTS 3

`endif
